// ==== pktgen_regfile.f ====
+incdir+include
hw/pktgen_regfile_pkg.sv
hw/pktgen_reg_decode.sv
hw/pktgen_reg_execute.sv
hw/pktgen_reg_result.sv
hw/pktgen_regfile.sv
verification/pktgen_regfile_properties.sv
verification/pktgen_regfile_tb.sv

// ==== verification/pktgen_regfile_tb.sv ====
// Frame generator register file testbench with random requests checked against a model
`timescale 1ns/10ps
`default_nettype none

`include "pktgen_regfile_cfg.svh"

module pktgen_regfile_tb;

  localparam int N_REQ      = 600;
  localparam int MAX_CYCLES = N_REQ * 3 + 200;

  logic                           clk_i;
  logic                           rstb_i;
  logic                           req_valid_i;
  pktgen_regfile_pkg::req_t       req_i;
  pktgen_regfile_pkg::status_t    status_i;
  logic                           resp_valid_o;
  pktgen_regfile_pkg::resp_t      resp_o;
  pktgen_regfile_pkg::frame_cfg_t cfg_o;

  integer                         seed;
  int                             cycle_cnt;
  pktgen_regfile_pkg::frame_cfg_t model_cfg;
  pktgen_regfile_pkg::status_t    model_status_q;
  pktgen_regfile_pkg::resp_t      exp_q[$];
  int                             accept_q[$];
  pktgen_regfile_pkg::resp_t      exp_resp;
  int                             accept_cyc;

  pktgen_regfile i_pktgen_regfile (
    .clk_i        (clk_i),
    .rstb_i       (rstb_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .status_i     (status_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .cfg_o        (cfg_o)
  );

  bind pktgen_regfile pktgen_regfile_properties i_properties (
    .clk_i        (clk_i),
    .rstb_i       (rstb_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .cfg_o        (cfg_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_resp(input pktgen_regfile_pkg::resp_t got,
                            input pktgen_regfile_pkg::resp_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error at %0t: response error=%0b data=%h, expected %0b %h",
                                  $time, got.error, got.rdata, exp.error, exp.rdata));
    end
  endtask

  task automatic check_cfg(input pktgen_regfile_pkg::frame_cfg_t got,
                           input pktgen_regfile_pkg::frame_cfg_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error at %0t: cfg_o=%h, expected %h", $time, got, exp));
    end
  endtask

  function automatic pktgen_regfile_pkg::frame_cfg_t reset_cfg();
    pktgen_regfile_pkg::frame_cfg_t c;
    c                   = '0;
    c.ctrl.enable       = 1'b1;
    c.ctrl.send_mode    = 1'b1;
    c.ctrl.pkt_len_mode = 1'b1;
    c.ctrl.payload_mode = 2'd2;
    c.send_cnt_lo       = `PKTGEN_RST_SEND_CNT_LO;
    c.send_cnt_hi       = `PKTGEN_RST_SEND_CNT_HI;
    c.pkt_len_init      = `PKTGEN_RST_PKT_LEN;
    c.ifg               = `PKTGEN_RST_IFG;
    c.da_l              = `PKTGEN_RST_DA_L;
    c.da_m              = `PKTGEN_RST_DA_M;
    c.da_h              = `PKTGEN_RST_DA_H;
    c.sa_l              = `PKTGEN_RST_SA_L;
    c.sa_m              = `PKTGEN_RST_SA_M;
    c.sa_h              = `PKTGEN_RST_SA_H;
    c.etype             = `PKTGEN_RST_ETYPE;
    return c;
  endfunction

  // Writable words 0x002..0x00D follow the config struct order
  function automatic bit is_writable(input int a);
    return (a >= 'h002) && (a <= 'h00D);
  endfunction

  function automatic bit is_read_only(input int a);
    return (a == 'h001) || ((a >= 'h00F) && (a <= 'h011));
  endfunction

  function automatic logic [15:0] model_read(input int a);
    logic [15:0] w;
    case (a)
      'h001:   w = model_status_q.chip_ver;
      'h00F:   w = model_status_q.total_l;
      'h010:   w = model_status_q.total_m;
      'h011:   w = model_status_q.total_h;
      default: w = model_cfg[(13 - a) * 16 +: 16];
    endcase
    if (a == 'h002) begin
      w[12] = model_status_q.send_done;
    end
    return w;
  endfunction

  function automatic pktgen_regfile_pkg::resp_t expected_resp(input pktgen_regfile_pkg::req_t r);
    pktgen_regfile_pkg::resp_t e;
    int                        a;
    a = int'(r.addr);
    e = '0;
    if (!is_writable(a) && !is_read_only(a)) begin
      e.error = 1'b1;
    end else if (r.we) begin
      e.error = is_read_only(a);
    end else begin
      e.rdata = model_read(a);
    end
    return e;
  endfunction

  // Register model updated on the edge where the DUT accepts
  always @(posedge clk_i) begin
    if (rstb_i) begin
      check_cfg(cfg_o, model_cfg);
      if (resp_valid_o) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("A response arrived with no request outstanding");
        end else begin
          exp_resp   = exp_q.pop_front();
          accept_cyc = accept_q.pop_front();
          if (cycle_cnt != accept_cyc + `PKTGEN_RESP_LAT) begin
            stop_with_failure($sformatf("Error at %0t: response after %0d cycles", $time,
                                        cycle_cnt - accept_cyc));
          end
          check_resp(resp_o, exp_resp);
        end
      end
      if (req_valid_i) begin
        exp_q.push_back(expected_resp(req_i));
        accept_q.push_back(cycle_cnt);
        if (req_i.we && is_writable(int'(req_i.addr))) begin
          model_cfg[(13 - int'(req_i.addr)) * 16 +: 16] = req_i.wdata;
          // send_done and reserved bits never stored
          if (req_i.addr == pktgen_regfile_pkg::CTRL) begin
            model_cfg.ctrl = pktgen_regfile_pkg::ctrl_t'(req_i.wdata & 16'hEF80);
          end
        end
      end
      model_status_q = status_i;
    end
  end

  // Failures of the bound assertions end the run
  always @(i_pktgen_regfile.i_properties.fail_cnt) begin
    if (i_pktgen_regfile.i_properties.fail_cnt != 0) begin
      stop_with_failure("A port assertion of the register file failed");
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "Timeout");
    end
  end

  task automatic send_request(input logic we, input logic [9:0] addr, input logic [15:0] wdata);
    pktgen_regfile_pkg::req_t r;
    r.we    = we;
    r.addr  = pktgen_regfile_pkg::reg_addr_e'(addr);
    r.wdata = wdata;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= r;
  endtask

  // Status moves only in idle cycles
  task automatic drive_idle(input bit new_status);
    logic [95:0] raw;
    raw = {$random(seed), $random(seed), $random(seed)};
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    req_i       <= '0;
    if (new_status) begin
      status_i <= raw[64:0];
    end
  endtask

  initial begin : stimulus
    logic [9:0] addr;
    logic       we;
    int         gap;
    seed           = 57154;
    clk_i          = 1'b0;
    rstb_i         = 1'b0;
    req_valid_i    = 1'b0;
    req_i          = '0;
    status_i       = '0;
    cycle_cnt      = 0;
    model_cfg      = reset_cfg();
    model_status_q = '0;
    repeat (2) @(posedge clk_i);
    rstb_i <= 1'b1;
    // Whole map read back to back after reset
    for (int a = 1; a <= 'h11; a++) begin
      send_request(1'b0, 10'(a), 16'h0000);
    end
    for (int i = 0; i < N_REQ; i++) begin
      gap = {$random(seed)} % 3;
      for (int g = 0; g < gap; g++) begin
        drive_idle(({$random(seed)} % 2) == 0);
      end
      we = 1'($random(seed));
      if (({$random(seed)} % 8) == 0) begin
        addr = 10'($random(seed));
      end else begin
        addr = 10'({$random(seed)} % 19);
      end
      send_request(we, addr, 16'($random(seed)));
    end
    drive_idle(1'b0);
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/pktgen_regfile_properties.sv ====
// Port properties of the register file covering response latency, idle response and config stability
`timescale 1ns/10ps
`default_nettype none

`include "pktgen_regfile_cfg.svh"

module pktgen_regfile_properties (
  input wire logic                           clk_i,
  input wire logic                           rstb_i,
  input wire logic                           req_valid_i,
  input wire pktgen_regfile_pkg::req_t       req_i,
  input wire logic                           resp_valid_o,
  input wire pktgen_regfile_pkg::resp_t      resp_o,
  input wire pktgen_regfile_pkg::frame_cfg_t cfg_o
);

  int fail_cnt = 0;

  // One response beat per request at a fixed latency
  resp_latency_a: assert property (
    @(posedge clk_i) disable iff (!rstb_i)
    $past(rstb_i, `PKTGEN_RESP_LAT) |->
      resp_valid_o == $past(req_valid_i, `PKTGEN_RESP_LAT)
  ) else begin
    $error("resp_valid_o does not follow req_valid_i by the response latency");
    fail_cnt++;
  end

  resp_idle_zero_a: assert property (
    @(posedge clk_i) disable iff (!rstb_i)
    !resp_valid_o |-> (resp_o == '0)
  ) else begin
    $error("resp_o is not zero while resp_valid_o is low");
    fail_cnt++;
  end

  // Only an accepted write may move the configuration
  cfg_stable_a: assert property (
    @(posedge clk_i) disable iff (!rstb_i)
    !(req_valid_i && req_i.we) |=> $stable(cfg_o)
  ) else begin
    $error("cfg_o changed without a write request");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// ==== hw/pktgen_regfile.sv ====
// Frame generator control and status register file top level
`timescale 1ns/10ps
`default_nettype none

module pktgen_regfile (
  input  wire logic                         clk_i,
  input  wire logic                         rstb_i,
  input  wire logic                         req_valid_i,
  input  wire pktgen_regfile_pkg::req_t     req_i,
  input  wire pktgen_regfile_pkg::status_t  status_i,
  output logic                              resp_valid_o,
  output pktgen_regfile_pkg::resp_t         resp_o,
  output pktgen_regfile_pkg::frame_cfg_t    cfg_o
);

  pktgen_regfile_pkg::wr_sel_t    wr_sel;
  pktgen_regfile_pkg::reg_addr_e  rd_sel;
  logic                           req_err;
  logic                           req_fire;
  pktgen_regfile_pkg::frame_cfg_t cfg;
  pktgen_regfile_pkg::status_t    status_q;

  pktgen_reg_decode i_decode (
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .wr_sel_o    (wr_sel),
    .rd_sel_o    (rd_sel),
    .req_err_o   (req_err),
    .req_fire_o  (req_fire)
  );

  pktgen_reg_execute i_execute (
    .clk_i    (clk_i),
    .rstb_i   (rstb_i),
    .wr_sel_i (wr_sel),
    .wdata_i  (req_i.wdata),
    .status_i (status_i),
    .cfg_o    (cfg),
    .status_o (status_q)
  );

  pktgen_reg_result i_result (
    .clk_i        (clk_i),
    .rstb_i       (rstb_i),
    .req_fire_i   (req_fire),
    .we_i         (req_i.we),
    .rd_sel_i     (rd_sel),
    .req_err_i    (req_err),
    .cfg_i        (cfg),
    .status_i     (status_q),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  assign cfg_o = cfg;

endmodule

`default_nettype wire

// ==== hw/pktgen_reg_result.sv ====
// Read data selection and fixed-latency response pipeline
`timescale 1ns/10ps
`default_nettype none

`include "pktgen_regfile_cfg.svh"

module pktgen_reg_result (
  input  wire logic                           clk_i,
  input  wire logic                           rstb_i,
  input  wire logic                           req_fire_i,
  input  wire logic                           we_i,
  input  wire pktgen_regfile_pkg::reg_addr_e  rd_sel_i,
  input  wire logic                           req_err_i,
  input  wire pktgen_regfile_pkg::frame_cfg_t cfg_i,
  input  wire pktgen_regfile_pkg::status_t    status_i,
  output logic                                resp_valid_o,
  output pktgen_regfile_pkg::resp_t           resp_o
);

  localparam int LAT = `PKTGEN_RESP_LAT;

  logic [`PKTGEN_DATA_W-1:0]                rd_word;
  pktgen_regfile_pkg::resp_t                resp_d;
  logic [LAT-1:0]                           valid_q;
  pktgen_regfile_pkg::resp_t [LAT-1:0]      resp_q;

  always_comb begin
    pktgen_regfile_pkg::ctrl_t ctrl_rd;
    ctrl_rd           = cfg_i.ctrl;
    ctrl_rd.send_done = status_i.send_done;
    case (rd_sel_i)
      pktgen_regfile_pkg::CHIP_VER:     rd_word = status_i.chip_ver;
      pktgen_regfile_pkg::CTRL:         rd_word = ctrl_rd;
      pktgen_regfile_pkg::SEND_CNT_LO:  rd_word = cfg_i.send_cnt_lo;
      pktgen_regfile_pkg::SEND_CNT_HI:  rd_word = cfg_i.send_cnt_hi;
      pktgen_regfile_pkg::PKT_LEN_INIT: rd_word = cfg_i.pkt_len_init;
      pktgen_regfile_pkg::IFG:          rd_word = cfg_i.ifg;
      pktgen_regfile_pkg::DA_L:         rd_word = cfg_i.da_l;
      pktgen_regfile_pkg::DA_M:         rd_word = cfg_i.da_m;
      pktgen_regfile_pkg::DA_H:         rd_word = cfg_i.da_h;
      pktgen_regfile_pkg::SA_L:         rd_word = cfg_i.sa_l;
      pktgen_regfile_pkg::SA_M:         rd_word = cfg_i.sa_m;
      pktgen_regfile_pkg::SA_H:         rd_word = cfg_i.sa_h;
      pktgen_regfile_pkg::ETYPE:        rd_word = cfg_i.etype;
      pktgen_regfile_pkg::TOTAL_L:      rd_word = status_i.total_l;
      pktgen_regfile_pkg::TOTAL_M:      rd_word = status_i.total_m;
      pktgen_regfile_pkg::TOTAL_H:      rd_word = status_i.total_h;
      default:                          rd_word = '0;
    endcase
  end

  // Writes and errors answer with zero data
  assign resp_d.error = req_err_i;
  assign resp_d.rdata = (we_i || req_err_i) ? '0 : rd_word;

  always_ff @(posedge clk_i or negedge rstb_i) begin
    if (!rstb_i) begin
      valid_q <= '0;
      resp_q  <= '0;
    end else begin
      valid_q   <= {valid_q[LAT-2:0], req_fire_i};
      resp_q[0] <= req_fire_i ? resp_d : '0;
      for (int i = 1; i < LAT; i++) begin
        resp_q[i] <= resp_q[i-1];
      end
    end
  end

  assign resp_valid_o = valid_q[LAT-1];
  assign resp_o       = resp_q[LAT-1];

endmodule

`default_nettype wire

// ==== hw/pktgen_reg_execute.sv ====
// Configuration register bank with reset values and a sampled copy of the status inputs
`timescale 1ns/10ps
`default_nettype none

`include "pktgen_regfile_cfg.svh"

module pktgen_reg_execute (
  input  wire logic                          clk_i,
  input  wire logic                          rstb_i,
  input  wire pktgen_regfile_pkg::wr_sel_t   wr_sel_i,
  input  wire logic [`PKTGEN_DATA_W-1:0]     wdata_i,
  input  wire pktgen_regfile_pkg::status_t   status_i,
  output pktgen_regfile_pkg::frame_cfg_t     cfg_o,
  output pktgen_regfile_pkg::status_t        status_o
);

  pktgen_regfile_pkg::frame_cfg_t cfg_q;
  pktgen_regfile_pkg::status_t    status_q;
  pktgen_regfile_pkg::ctrl_t      ctrl_wr;

  assign ctrl_wr = pktgen_regfile_pkg::ctrl_t'(wdata_i);

  always_ff @(posedge clk_i or negedge rstb_i) begin
    if (!rstb_i) begin
      cfg_q.ctrl         <= `PKTGEN_RST_CTRL;
      cfg_q.send_cnt_lo  <= `PKTGEN_RST_SEND_CNT_LO;
      cfg_q.send_cnt_hi  <= `PKTGEN_RST_SEND_CNT_HI;
      cfg_q.pkt_len_init <= `PKTGEN_RST_PKT_LEN;
      cfg_q.ifg          <= `PKTGEN_RST_IFG;
      cfg_q.da_l         <= `PKTGEN_RST_DA_L;
      cfg_q.da_m         <= `PKTGEN_RST_DA_M;
      cfg_q.da_h         <= `PKTGEN_RST_DA_H;
      cfg_q.sa_l         <= `PKTGEN_RST_SA_L;
      cfg_q.sa_m         <= `PKTGEN_RST_SA_M;
      cfg_q.sa_h         <= `PKTGEN_RST_SA_H;
      cfg_q.etype        <= `PKTGEN_RST_ETYPE;
    end else begin
      // send_done and the reserved bits are not writable
      if (wr_sel_i.ctrl) begin
        cfg_q.ctrl.enable       <= ctrl_wr.enable;
        cfg_q.ctrl.suspend      <= ctrl_wr.suspend;
        cfg_q.ctrl.send_mode    <= ctrl_wr.send_mode;
        cfg_q.ctrl.pkt_len_mode <= ctrl_wr.pkt_len_mode;
        cfg_q.ctrl.payload_mode <= ctrl_wr.payload_mode;
        cfg_q.ctrl.soft_reset   <= ctrl_wr.soft_reset;
        cfg_q.ctrl.count_clr    <= ctrl_wr.count_clr;
      end
      if (wr_sel_i.send_cnt_lo) begin
        cfg_q.send_cnt_lo <= wdata_i;
      end
      if (wr_sel_i.send_cnt_hi) begin
        cfg_q.send_cnt_hi <= wdata_i;
      end
      if (wr_sel_i.pkt_len_init) begin
        cfg_q.pkt_len_init <= wdata_i;
      end
      if (wr_sel_i.ifg) begin
        cfg_q.ifg <= wdata_i;
      end
      if (wr_sel_i.da_l) begin
        cfg_q.da_l <= wdata_i;
      end
      if (wr_sel_i.da_m) begin
        cfg_q.da_m <= wdata_i;
      end
      if (wr_sel_i.da_h) begin
        cfg_q.da_h <= wdata_i;
      end
      if (wr_sel_i.sa_l) begin
        cfg_q.sa_l <= wdata_i;
      end
      if (wr_sel_i.sa_m) begin
        cfg_q.sa_m <= wdata_i;
      end
      if (wr_sel_i.sa_h) begin
        cfg_q.sa_h <= wdata_i;
      end
      if (wr_sel_i.etype) begin
        cfg_q.etype <= wdata_i;
      end
    end
  end

  // Status sampled every cycle
  always_ff @(posedge clk_i or negedge rstb_i) begin
    if (!rstb_i) begin
      status_q <= '0;
    end else begin
      status_q <= status_i;
    end
  end

  assign cfg_o    = cfg_q;
  assign status_o = status_q;

endmodule

`default_nettype wire

// ==== hw/pktgen_reg_decode.sv ====
// Register request decoder: classifies the address, raises write strobes and flags errors
`timescale 1ns/10ps
`default_nettype none

module pktgen_reg_decode (
  input  wire logic                          req_valid_i,
  input  wire pktgen_regfile_pkg::req_t      req_i,
  output pktgen_regfile_pkg::wr_sel_t        wr_sel_o,
  output pktgen_regfile_pkg::reg_addr_e      rd_sel_o,
  output logic                               req_err_o,
  output logic                               req_fire_o
);

  pktgen_regfile_pkg::wr_sel_t wr_hit;
  logic                        mapped;
  logic                        read_only;

  always_comb begin
    wr_hit    = '0;
    mapped    = 1'b1;
    read_only = 1'b0;
    case (req_i.addr)
      pktgen_regfile_pkg::CTRL:         wr_hit.ctrl         = 1'b1;
      pktgen_regfile_pkg::SEND_CNT_LO:  wr_hit.send_cnt_lo  = 1'b1;
      pktgen_regfile_pkg::SEND_CNT_HI:  wr_hit.send_cnt_hi  = 1'b1;
      pktgen_regfile_pkg::PKT_LEN_INIT: wr_hit.pkt_len_init = 1'b1;
      pktgen_regfile_pkg::IFG:          wr_hit.ifg          = 1'b1;
      pktgen_regfile_pkg::DA_L:         wr_hit.da_l         = 1'b1;
      pktgen_regfile_pkg::DA_M:         wr_hit.da_m         = 1'b1;
      pktgen_regfile_pkg::DA_H:         wr_hit.da_h         = 1'b1;
      pktgen_regfile_pkg::SA_L:         wr_hit.sa_l         = 1'b1;
      pktgen_regfile_pkg::SA_M:         wr_hit.sa_m         = 1'b1;
      pktgen_regfile_pkg::SA_H:         wr_hit.sa_h         = 1'b1;
      pktgen_regfile_pkg::ETYPE:        wr_hit.etype        = 1'b1;
      // Status words come from the frame generator
      pktgen_regfile_pkg::CHIP_VER,
      pktgen_regfile_pkg::TOTAL_L,
      pktgen_regfile_pkg::TOTAL_M,
      pktgen_regfile_pkg::TOTAL_H:      read_only           = 1'b1;
      default:                          mapped              = 1'b0;
    endcase
  end

  // Strobe only on a legal write
  assign wr_sel_o   = (req_valid_i && req_i.we) ? wr_hit : '0;
  assign req_err_o  = req_valid_i && (!mapped || (req_i.we && read_only));
  assign rd_sel_o   = req_i.addr;
  assign req_fire_o = req_valid_i;

endmodule

`default_nettype wire

// ==== hw/pktgen_regfile_pkg.sv ====
// Frame generator register file types: address map, request, response, config and status
`default_nettype none

`include "pktgen_regfile_cfg.svh"

package pktgen_regfile_pkg;

  typedef enum logic [`PKTGEN_ADDR_W-1:0] {
    CHIP_VER     = 10'h001,
    CTRL         = 10'h002,
    SEND_CNT_LO  = 10'h003,
    SEND_CNT_HI  = 10'h004,
    PKT_LEN_INIT = 10'h005,
    IFG          = 10'h006,
    DA_L         = 10'h007,
    DA_M         = 10'h008,
    DA_H         = 10'h009,
    SA_L         = 10'h00A,
    SA_M         = 10'h00B,
    SA_H         = 10'h00C,
    ETYPE        = 10'h00D,
    TOTAL_L      = 10'h00F,
    TOTAL_M      = 10'h010,
    TOTAL_H      = 10'h011
  } reg_addr_e;

  // Control word at CTRL
  typedef struct packed {
    logic       enable;
    logic       suspend;
    logic       send_mode;
    logic       send_done;
    logic       pkt_len_mode;
    logic [1:0] payload_mode;
    logic       soft_reset;
    logic       count_clr;
    logic [6:0] reserved;
  } ctrl_t;

  typedef struct packed {
    logic                     we;
    reg_addr_e                addr;
    logic [`PKTGEN_DATA_W-1:0] wdata;
  } req_t;

  typedef struct packed {
    logic                     error;
    logic [`PKTGEN_DATA_W-1:0] rdata;
  } resp_t;

  typedef struct packed {
    ctrl_t                    ctrl;
    logic [`PKTGEN_DATA_W-1:0] send_cnt_lo;
    logic [`PKTGEN_DATA_W-1:0] send_cnt_hi;
    logic [`PKTGEN_DATA_W-1:0] pkt_len_init;
    logic [`PKTGEN_DATA_W-1:0] ifg;
    logic [`PKTGEN_DATA_W-1:0] da_l;
    logic [`PKTGEN_DATA_W-1:0] da_m;
    logic [`PKTGEN_DATA_W-1:0] da_h;
    logic [`PKTGEN_DATA_W-1:0] sa_l;
    logic [`PKTGEN_DATA_W-1:0] sa_m;
    logic [`PKTGEN_DATA_W-1:0] sa_h;
    logic [`PKTGEN_DATA_W-1:0] etype;
  } frame_cfg_t;

  // Inputs from the frame generator
  typedef struct packed {
    logic                     send_done;
    logic [`PKTGEN_DATA_W-1:0] chip_ver;
    logic [`PKTGEN_DATA_W-1:0] total_l;
    logic [`PKTGEN_DATA_W-1:0] total_m;
    logic [`PKTGEN_DATA_W-1:0] total_h;
  } status_t;

  // One strobe per writable register
  typedef struct packed {
    logic ctrl;
    logic send_cnt_lo;
    logic send_cnt_hi;
    logic pkt_len_init;
    logic ifg;
    logic da_l;
    logic da_m;
    logic da_h;
    logic sa_l;
    logic sa_m;
    logic sa_h;
    logic etype;
  } wr_sel_t;

endpackage

`default_nettype wire

// ==== include/pktgen_regfile_cfg.svh ====
// Frame generator register file configuration: widths, response latency and reset values
`ifndef PKTGEN_REGFILE_CFG_SVH
`define PKTGEN_REGFILE_CFG_SVH

// Request port widths
`define PKTGEN_ADDR_W 10
`define PKTGEN_DATA_W 16

// Register stages from request to response
`define PKTGEN_RESP_LAT 3

// Packet send count
`define PKTGEN_RST_SEND_CNT_LO 16'h0100
`define PKTGEN_RST_SEND_CNT_HI 16'h0000

// Frame length and inter-frame gap
`define PKTGEN_RST_PKT_LEN 16'h0064
`define PKTGEN_RST_IFG 16'h0012

// Destination MAC, low word first
`define PKTGEN_RST_DA_L 16'hEEFF
`define PKTGEN_RST_DA_M 16'hCCDD
`define PKTGEN_RST_DA_H 16'hAABB

// Source MAC, low word first
`define PKTGEN_RST_SA_L 16'h4455
`define PKTGEN_RST_SA_M 16'h2233
`define PKTGEN_RST_SA_H 16'h0011

`define PKTGEN_RST_ETYPE 16'h8800

// enable=1 suspend=0 send_mode=1 pkt_len_mode=1 payload_mode=2, rest zero
`define PKTGEN_RST_CTRL 16'hAC00

`endif
